/* bench/core_testdata.txt */
# P <byte address hex> <instruction hex>   S <store address hex> <store data hex> <mask hex>
# E <number of expected stores, decimal>
P 00000000 123450B7
P 00000004 67808093
P 00000008 10000113
P 0000000C F8500193
P 00000010 ABC00213
P 00000014 00112023
P 00000018 00110823
P 0000001C 003108A3
P 00000020 00110923
P 00000024 003109A3
P 00000028 02411023
P 0000002C 02111123
P 00000030 01110283
P 00000034 02512823
P 00000038 01314303
P 0000003C 02612A23
P 00000040 02011383
P 00000044 02712C23
P 00000048 02015403
P 0000004C 02812E23
P 00000050 00708533
P 00000054 04A12023
P 00000058 401285B3
P 0000005C 04B12223
P 00000060 0012A633
P 00000064 04C12423
P 00000068 4043D693
P 0000006C 04D12623
P 00000070 0030C733
P 00000074 04E12823
P 00000078 00000793
P 0000007C 00500813
P 00000080 00378793
P 00000084 FFF80813
P 00000088 FE081CE3
P 0000008C 04F12A23
P 00000090 00C008EF
P 00000094 05212E23
P 00000098 0000006F
P 0000009C 05112C23
P 000000A0 00088967
S 00000100 12345678 F
S 00000110 78787878 1
S 00000110 85858585 2
S 00000110 78787878 4
S 00000110 85858585 8
S 00000120 FABCFABC 3
S 00000120 56785678 C
S 00000130 FFFFFF85 F
S 00000134 00000085 F
S 00000138 FFFFFABC F
S 0000013C 0000FABC F
S 00000140 12345134 F
S 00000144 EDCBA90D F
S 00000148 00000001 F
S 0000014C FFFFFFAB F
S 00000150 EDCBA9FD F
S 00000154 0000000F F
S 00000158 00000094 F
S 0000015C 000000A4 F
E 19

/* src.f */
verilog/rv_pkg.sv
verilog/instr_decoder.sv
verilog/register_file.sv
verilog/alu.sv
verilog/lsu.sv
verilog/pc_unit.sv
verilog/control_unit.sv
verilog/rv_core.sv
bench/tb_core.sv

/* bench/tb_core.sv */
`timescale 1ns/1ps

module tb_core import rv_pkg::*;;

    localparam word_t RESET_VECTOR = 32'h0000_0000;
    localparam int    CLK_PERIOD   = 4;
    localparam int    RESET_CYCLES = 8;
    localparam int    DRIVE_DELAY  = 1;
    localparam int    MAX_STORES   = 64;
    localparam word_t HALT_INSN    = 32'h0000_006f;

    logic      clk;
    logic      rst;
    word_t     imem_addr;
    word_t     imem_data;
    dmem_req_t dmem_req;
    dmem_rsp_t dmem_rsp;

    word_t      imem [0:255];
    logic [7:0] dmem [0:1023];
    word_t      exp_addr [0:MAX_STORES-1];
    word_t      exp_data [0:MAX_STORES-1];
    byte_mask_t exp_mask [0:MAX_STORES-1];
    int         exp_count;
    int         prog_words;
    int         store_idx;
    logic       testdata_loaded;
    logic [31:0] rng_state;
    logic       prev_req;
    logic       prev_ack;
    dmem_req_t  prev_bus;
    int         check_count;
    int         reset_errors;
    int         trace_errors;
    int         count_errors;
    int         protocol_errors;

    rv_core #(.RESET_VECTOR(RESET_VECTOR)) u_dut (
        .clk       (clk),
        .rst       (rst),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .dmem_req  (dmem_req),
        .dmem_rsp  (dmem_rsp)
    );

    // Combinational fetch port.
    assign imem_data = imem[imem_addr[9:2]];

    initial begin : clock_gen
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic wait_random_cycles();
        rng_state = xorshift32(rng_state);
        repeat (rng_state[1:0]) @(negedge clk);
    endtask

    task automatic load_testdata(output logic open_ok);
        int fd;
        int c;
        int r;
        int i;
        word_t a;
        word_t d;
        word_t m;
        logic [8*128-1:0] line;
        for (i = 0; i < 256; i++) begin
            imem[i] = '0;
        end
        prog_words = 0;
        exp_count  = 0;
        fd = $fopen("bench/core_testdata.txt", "r");
        open_ok = (fd != 0);
        if (open_ok) begin
            while (!$feof(fd)) begin
                c = $fgetc(fd);
                case (c)
                    "#": r = $fgets(line, fd);
                    "P": begin
                        r = $fscanf(fd, " %h %h", a, d);
                        imem[a[9:2]] = d;
                        prog_words++;
                    end
                    "S": begin
                        r = $fscanf(fd, " %h %h %h", a, d, m);
                        exp_addr[store_idx] = a;
                        exp_data[store_idx] = d;
                        exp_mask[store_idx] = m[3:0];
                        store_idx++;
                    end
                    "E": r = $fscanf(fd, " %d", exp_count);
                    default: ;
                endcase
            end
            $fclose(fd);
            store_idx = 0;
        end
    endtask

    // Byte-addressed data memory behind a word-aligned bus.
    task automatic serve_access();
        int i;
        logic [9:0] base;
        base = dmem_req.addr[9:0];
        if (dmem_req.we) begin
            for (i = 0; i < 4; i++) begin
                if (dmem_req.mask[i]) begin
                    dmem[base + i] = dmem_req.wdata[8*i +: 8];
                end
            end
        end else begin
            dmem_rsp.rdata = {dmem[base + 3], dmem[base + 2], dmem[base + 1], dmem[base]};
        end
    endtask

    initial begin : memory_model
        int j;
        dmem_rsp  = '0;
        rng_state = 32'd34237;
        for (j = 0; j < 1024; j++) begin
            dmem[j] = 8'h00;
        end
        forever begin
            @(negedge clk);
            if (!rst && dmem_req.req && !dmem_rsp.ack) begin
                wait_random_cycles();
                @(posedge clk);
                #DRIVE_DELAY;
                serve_access();
                dmem_rsp.ack = 1'b1;
                @(negedge clk);
                while (dmem_req.req) begin
                    @(negedge clk);
                end
                wait_random_cycles();
                @(posedge clk);
                #DRIVE_DELAY;
                dmem_rsp.ack = 1'b0;
            end
        end
    end

    task automatic check_store();
        check_count++;
        assert (store_idx < exp_count) else begin
            $display("Store to %h arrived after all %0d expected stores", dmem_req.addr,
                     exp_count);
            trace_errors++;
        end
        if (store_idx < exp_count) begin
            check_count += 3;
            assert (dmem_req.addr == exp_addr[store_idx]) else begin
                $display("ERROR dmem_req.addr (store %0d): got %h, expected %h", store_idx,
                         dmem_req.addr, exp_addr[store_idx]);
                trace_errors++;
            end
            assert (dmem_req.wdata == exp_data[store_idx]) else begin
                $display("ERROR dmem_req.wdata (store %0d): got %h, expected %h", store_idx,
                         dmem_req.wdata, exp_data[store_idx]);
                trace_errors++;
            end
            assert (dmem_req.mask == exp_mask[store_idx]) else begin
                $display("ERROR dmem_req.mask (store %0d): got %h, expected %h", store_idx,
                         dmem_req.mask, exp_mask[store_idx]);
                trace_errors++;
            end
        end
        store_idx++;
    endtask

    always @(negedge clk) begin : bus_monitor
        if (!rst) begin
            check_count += 3;
            assert (!(prev_req && !prev_ack && !dmem_req.req)) else begin
                $display("Bus protocol broken at %0t: req dropped before ack was seen", $time);
                protocol_errors++;
            end
            assert (!(!prev_req && prev_ack && dmem_req.req)) else begin
                $display("Bus protocol broken at %0t: req rose while ack was still high",
                         $time);
                protocol_errors++;
            end
            assert (!(prev_req && dmem_req.req && dmem_req != prev_bus)) else begin
                $display("Bus protocol broken at %0t: request fields changed while req was high",
                         $time);
                protocol_errors++;
            end
            if (dmem_req.req && !prev_req && dmem_req.we) begin
                check_store();
            end
        end
        prev_req = dmem_req.req;
        prev_ack = dmem_rsp.ack;
        prev_bus = dmem_req;
    end

    task automatic report_test(input string name, input int errors);
        if (errors == 0) begin
            $display("test %s: pass", name);
        end else begin
            $display("test %s: FAIL (%0d)", name, errors);
        end
    endtask

    task automatic run_all();
        int total_errors;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        @(negedge clk);
        check_count += 2;
        assert (dmem_req.req == 1'b0) else begin
            $display("ERROR dmem_req.req after reset: got %h, expected %h", dmem_req.req, 1'b0);
            reset_errors++;
        end
        assert (imem_addr == RESET_VECTOR) else begin
            $display("ERROR imem_addr after reset: got %h, expected %h", imem_addr,
                     RESET_VECTOR);
            reset_errors++;
        end
        report_test("reset_state", reset_errors);
        // The program ends in a jump to itself.
        while (!(imem_data == HALT_INSN && !dmem_req.req && !dmem_rsp.ack)) begin
            @(negedge clk);
        end
        check_count++;
        assert (store_idx == exp_count) else begin
            $display("ERROR store_count: got %h, expected %h", store_idx, exp_count);
            count_errors++;
        end
        report_test("store_trace", trace_errors);
        report_test("store_count", count_errors);
        report_test("bus_protocol", protocol_errors);
        total_errors = reset_errors + trace_errors + count_errors + protocol_errors;
        $display("Summary: 4 tests, %0d checks, %0d failed checks", check_count, total_errors);
        if (total_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    endtask

    initial begin : watchdog
        wait (testdata_loaded);
        repeat (RESET_CYCLES + 40 * prog_words + 10 * exp_count) @(posedge clk);
        $display("Timeout: the program did not reach its halt loop in time");
        $display("Errors found");
        $finish;
    end

    initial begin : main_sequence
        logic open_ok;
        rst             = 1'b1;
        testdata_loaded = 1'b0;
        store_idx       = 0;
        check_count     = 0;
        reset_errors    = 0;
        trace_errors    = 0;
        count_errors    = 0;
        protocol_errors = 0;
        prev_req        = 1'b0;
        prev_ack        = 1'b0;
        prev_bus        = '0;
        load_testdata(open_ok);
        if (!open_ok) begin
            $display("Cannot open bench/core_testdata.txt");
            $display("Errors found");
            $finish;
        end else begin
            testdata_loaded = 1'b1;
            run_all();
        end
    end

endmodule

/* verilog/rv_core.sv */
`timescale 1ns/1ps

module rv_core import rv_pkg::*; #(
    parameter word_t RESET_VECTOR = 32'h0000_0000
) (
    input  logic      clk,
    input  logic      rst,
    output word_t     imem_addr,
    input  word_t     imem_data,
    output dmem_req_t dmem_req,
    input  dmem_rsp_t dmem_rsp
);

    word_t      pc;
    word_t      pc_plus4;
    decoded_t   dec;
    src_a_e     src_a;
    src_b_e     src_b;
    alu_op_e    alu_op;
    wb_sel_e    wb_sel;
    logic       rf_we;
    logic       is_jump;
    logic       is_jalr;
    logic       is_branch;
    logic       mem_we;
    logic       req;
    logic       pc_stall;
    logic       take_branch;
    word_t      rdata1;
    word_t      rdata2;
    word_t      operand_a;
    word_t      operand_b;
    word_t      alu_result;
    word_t      rf_wdata;
    word_t      store_wdata;
    word_t      load_value;
    byte_mask_t mask;

    assign imem_addr = pc;

    // Word address on the bus. The lanes come from the mask.
    assign dmem_req.req   = req;
    assign dmem_req.we    = mem_we;
    assign dmem_req.addr  = {alu_result[31:2], 2'b00};
    assign dmem_req.wdata = store_wdata;
    assign dmem_req.mask  = mask;

    control_unit u_control (
        .clk       (clk),
        .rst       (rst),
        .dec       (dec),
        .ack       (dmem_rsp.ack),
        .src_a     (src_a),
        .src_b     (src_b),
        .alu_op    (alu_op),
        .wb_sel    (wb_sel),
        .rf_we     (rf_we),
        .is_jump   (is_jump),
        .is_jalr   (is_jalr),
        .is_branch (is_branch),
        .mem_we    (mem_we),
        .req       (req),
        .pc_stall  (pc_stall)
    );

    pc_unit #(.RESET_VECTOR(RESET_VECTOR)) u_pc (
        .clk         (clk),
        .rst         (rst),
        .pc_stall    (pc_stall),
        .is_jump     (is_jump),
        .is_jalr     (is_jalr),
        .take_branch (take_branch),
        .imm         (dec.imm),
        .alu_result  (alu_result),
        .pc          (pc),
        .pc_plus4    (pc_plus4)
    );

    instr_decoder u_decoder (
        .instr (imem_data),
        .dec   (dec)
    );

    register_file u_regs (
        .clk    (clk),
        .rs1    (dec.rs1),
        .rs2    (dec.rs2),
        .rd     (dec.rd),
        .wdata  (rf_wdata),
        .we     (rf_we),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    alu u_alu (
        .a           (operand_a),
        .b           (operand_b),
        .op          (alu_op),
        .funct3      (dec.funct3),
        .is_branch   (is_branch),
        .result      (alu_result),
        .take_branch (take_branch)
    );

    lsu u_lsu (
        .funct3     (dec.funct3),
        .addr       (alu_result),
        .store_data (rdata2),
        .rdata      (dmem_rsp.rdata),
        .mask       (mask),
        .wdata      (store_wdata),
        .load_value (load_value)
    );

    always_comb begin
        case (src_a)
            RS1:     operand_a = rdata1;
            PC:      operand_a = pc;
            default: operand_a = '0;
        endcase
        operand_b = (src_b == IMM) ? dec.imm : rdata2;
        case (wb_sel)
            LOAD:    rf_wdata = load_value;
            PC4:     rf_wdata = pc_plus4;
            default: rf_wdata = alu_result;
        endcase
    end

    // Halfword requests that reach the bus sit on an even byte address.
    assert property (@(posedge clk) disable iff (rst)
        dmem_req.req && dec.funct3[1:0] == 2'b01 |-> !alu_result[0]);

endmodule

/* verilog/control_unit.sv */
`timescale 1ns/1ps

module control_unit import rv_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  decoded_t dec,
    input  logic     ack,
    output src_a_e   src_a,
    output src_b_e   src_b,
    output alu_op_e  alu_op,
    output wb_sel_e  wb_sel,
    output logic     rf_we,
    output logic     is_jump,
    output logic     is_jalr,
    output logic     is_branch,
    output logic     mem_we,
    output logic     req,
    output logic     pc_stall
);

    mem_state_e state;
    mem_state_e state_next;
    logic       is_mem;
    logic       alt_op;
    alu_op_e    funct_op;

    assign is_mem = dec.opcode == OP_LOAD || dec.opcode == OP_STORE;

    // SUB only for register ops. SRA for both forms.
    assign alt_op = dec.funct7[5] && (dec.opcode == OP_REG || dec.funct3 == 3'b101);

    always_comb begin
        case (dec.funct3)
            3'b000:  funct_op = alt_op ? SUB : ADD;
            3'b001:  funct_op = SLL;
            3'b010:  funct_op = SLT;
            3'b011:  funct_op = SLTU;
            3'b100:  funct_op = XOR;
            3'b101:  funct_op = alt_op ? SRA : SRL;
            3'b110:  funct_op = OR;
            default: funct_op = AND;
        endcase
    end

    always_comb begin
        src_a     = RS1;
        src_b     = IMM;
        alu_op    = ADD;
        wb_sel    = ALU;
        rf_we     = 1'b0;
        is_jump   = 1'b0;
        is_jalr   = 1'b0;
        is_branch = 1'b0;
        mem_we    = 1'b0;
        case (dec.opcode)
            OP_LUI: begin
                src_a = ZERO;
                rf_we = 1'b1;
            end
            OP_AUIPC: begin
                src_a = PC;
                rf_we = 1'b1;
            end
            OP_JAL: begin
                wb_sel  = PC4;
                rf_we   = 1'b1;
                is_jump = 1'b1;
            end
            OP_JALR: begin
                wb_sel  = PC4;
                rf_we   = 1'b1;
                is_jalr = 1'b1;
            end
            OP_BRANCH: begin
                src_b     = RS2;
                alu_op    = SUB;
                is_branch = 1'b1;
            end
            OP_LOAD: begin
                wb_sel = LOAD;
                // Write back only while the returned data is valid.
                rf_we  = state == REQ && ack;
            end
            OP_STORE: begin
                mem_we = 1'b1;
            end
            OP_IMM: begin
                alu_op = funct_op;
                rf_we  = 1'b1;
            end
            OP_REG: begin
                src_b  = RS2;
                alu_op = funct_op;
                rf_we  = 1'b1;
            end
            default: ;
        endcase
    end

    always_comb begin
        state_next = state;
        pc_stall   = 1'b0;
        case (state)
            IDLE: begin
                if (is_mem) begin
                    state_next = REQ;
                    pc_stall   = 1'b1;
                end
            end
            REQ: begin
                pc_stall = 1'b1;
                if (ack) begin
                    state_next = RELEASE;
                end
            end
            RELEASE: begin
                if (ack) begin
                    pc_stall = 1'b1;
                end else begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    assign req = state == REQ;

    // Req and the instruction behind it hold until ack arrives.
    assert property (@(posedge clk) disable iff (rst) req && !ack |=> req && $stable(dec));

    // No new request while ack is still high.
    assert property (@(posedge clk) disable iff (rst) !req && ack |=> !req);

endmodule

/* verilog/pc_unit.sv */
`timescale 1ns/1ps

module pc_unit import rv_pkg::*; #(
    parameter word_t RESET_VECTOR = 32'h0000_0000
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  pc_stall,
    input  logic  is_jump,
    input  logic  is_jalr,
    input  logic  take_branch,
    input  word_t imm,
    input  word_t alu_result,
    output word_t pc,
    output word_t pc_plus4
);

    word_t next_pc;

    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        if (is_jalr) begin
            next_pc = {alu_result[31:1], 1'b0};
        end else if (is_jump || take_branch) begin
            next_pc = pc + imm;
        end else begin
            next_pc = pc_plus4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_VECTOR;
        end else if (!pc_stall) begin
            pc <= next_pc;
        end
    end

endmodule

/* verilog/lsu.sv */
`timescale 1ns/1ps

module lsu import rv_pkg::*; (
    input  logic [2:0] funct3,
    input  word_t      addr,
    input  word_t      store_data,
    input  word_t      rdata,
    output byte_mask_t mask,
    output word_t      wdata,
    output word_t      load_value
);

    logic [1:0] offset;
    word_t      shifted;

    always_comb begin
        case (funct3[1:0])
            2'b00: begin
                offset = addr[1:0];
                mask   = 4'b0001 << offset;
                wdata  = {4{store_data[7:0]}};
            end
            2'b01: begin
                offset = {addr[1], 1'b0};
                mask   = 4'b0011 << offset;
                wdata  = {2{store_data[15:0]}};
            end
            default: begin
                offset = 2'b00;
                mask   = 4'b1111;
                wdata  = store_data;
            end
        endcase
    end

    // Move the addressed lane down to bit 0.
    assign shifted = rdata >> {offset, 3'b000};

    always_comb begin
        case (funct3[1:0])
            2'b00: begin
                load_value = funct3[2] ? {24'b0, shifted[7:0]}
                                       : {{24{shifted[7]}}, shifted[7:0]};
            end
            2'b01: begin
                load_value = funct3[2] ? {16'b0, shifted[15:0]}
                                       : {{16{shifted[15]}}, shifted[15:0]};
            end
            default: load_value = rdata;
        endcase
    end

endmodule

/* verilog/alu.sv */
`timescale 1ns/1ps

module alu import rv_pkg::*; (
    input  word_t      a,
    input  word_t      b,
    input  alu_op_e    op,
    input  logic [2:0] funct3,
    input  logic       is_branch,
    output word_t      result,
    output logic       take_branch
);

    logic cond;

    always_comb begin
        case (op)
            SUB:     result = a - b;
            SLL:     result = a << b[4:0];
            SLT:     result = {31'b0, $signed(a) < $signed(b)};
            SLTU:    result = {31'b0, a < b};
            XOR:     result = a ^ b;
            SRL:     result = a >> b[4:0];
            SRA:     result = word_t'($signed(a) >>> b[4:0]);
            OR:      result = a | b;
            AND:     result = a & b;
            default: result = a + b;
        endcase
    end

    // Branch compare on the raw operands.
    always_comb begin
        case (funct3)
            3'b000:  cond = a == b;
            3'b001:  cond = a != b;
            3'b100:  cond = $signed(a) < $signed(b);
            3'b101:  cond = $signed(a) >= $signed(b);
            3'b110:  cond = a < b;
            3'b111:  cond = a >= b;
            default: cond = 1'b0;
        endcase
    end

    assign take_branch = is_branch && cond;

endmodule

/* verilog/register_file.sv */
`timescale 1ns/1ps

module register_file import rv_pkg::*; (
    input  logic     clk,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    input  reg_idx_t rd,
    input  word_t    wdata,
    input  logic     we,
    output word_t    rdata1,
    output word_t    rdata2
);

    word_t regs [0:31];

    always_ff @(posedge clk) begin
        if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    // x0 is never written. Force its read value.
    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* verilog/instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder import rv_pkg::*; (
    input  word_t    instr,
    output decoded_t dec
);

    always_comb begin
        dec.opcode = instr[6:0];
        dec.rd     = instr[11:7];
        dec.funct3 = instr[14:12];
        dec.rs1    = instr[19:15];
        dec.rs2    = instr[24:20];
        dec.funct7 = instr[31:25];
        case (instr[6:0])
            OP_LOAD, OP_IMM, OP_JALR: begin
                dec.imm = {{20{instr[31]}}, instr[31:20]};
            end
            OP_STORE: begin
                dec.imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            OP_BRANCH: begin
                dec.imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                           instr[11:8], 1'b0};
            end
            OP_LUI, OP_AUIPC: begin
                dec.imm = {instr[31:12], 12'b0};
            end
            OP_JAL: begin
                dec.imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                           instr[30:21], 1'b0};
            end
            default: dec.imm = '0;
        endcase
    end

endmodule

/* verilog/rv_pkg.sv */
package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [3:0]  byte_mask_t;
    typedef logic [6:0]  opcode_t;

    // Base opcodes the core executes.
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_AUIPC  = 7'b0010111;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_REG    = 7'b0110011;

    typedef enum logic [3:0] {ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND} alu_op_e;
    typedef enum logic [1:0] {RS1, PC, ZERO} src_a_e;
    typedef enum logic       {RS2, IMM} src_b_e;
    typedef enum logic [1:0] {ALU, LOAD, PC4} wb_sel_e;
    typedef enum logic [1:0] {IDLE, REQ, RELEASE} mem_state_e;

    typedef struct packed {
        logic       req;
        logic       we;
        word_t      addr;
        word_t      wdata;
        byte_mask_t mask;
    } dmem_req_t;

    typedef struct packed {
        logic  ack;
        word_t rdata;
    } dmem_rsp_t;

    typedef struct packed {
        opcode_t    opcode;
        logic [2:0] funct3;
        logic [6:0] funct7;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        reg_idx_t   rd;
        word_t      imm;
    } decoded_t;

endpackage
